//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Word and memory geometry
    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;
    // Opcode sits in the top bits of the instruction word
    localparam int OPCODE_W  = 4;

    // Data and instruction word
    typedef logic [DATA_W-1:0] word_t;
    // Address into either memory
    typedef logic [ADDR_W-1:0] addr_t;

    // Instruction opcodes, anything else runs as a no-op
    typedef enum logic [OPCODE_W-1:0] {
        OP_LDAC = 4'd1,
        OP_STAC = 4'd2,
        OP_MVAC = 4'd3,
        OP_ADD  = 4'd4,
        OP_SUB  = 4'd5,
        OP_MUL  = 4'd6,
        OP_INAC = 4'd7,
        OP_CLAC = 4'd8,
        OP_JPNZ = 4'd9,
        OP_END  = 4'd10
    } opcode_t;

    // ALU function select
    typedef enum logic [1:0] {
        ALU_NONE = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2,
        ALU_MUL  = 2'd3
    } alu_op_t;

    // Sequencer states
    typedef enum logic [5:0] {
        IDLE,
        FETCH1, FETCH2, FETCH3,
        LDAC1, LDAC2, LDAC3,
        STAC1, STAC2,
        MVAC1,
        ADD1, ADD2,
        SUB1, SUB2,
        MUL1, MUL2,
        INAC1,
        CLAC1,
        JPNZ1,
        NOP1,
        ENDOP
    } seq_state_t;

    // Registered strobes from the sequencer
    typedef struct packed {
        // Fetch side
        logic    im_rd;
        logic    ir_wr;
        logic    pc_inc;
        logic    pc_wr;
        logic    ar_wr;
        // Data memory and DR
        logic    dm_rd;
        logic    dm_wr;
        logic    dr_from_dm;
        logic    dr_from_ac;
        // AC and R sources
        logic    ac_from_dr;
        logic    ac_inc;
        logic    ac_clear;
        logic    ac_from_alu;
        logic    r_from_ac;
        alu_op_t alu_op;
    } ctrl_t;

    // Program / data load port
    typedef struct packed {
        logic  en;
        // 1 targets data memory, 0 instruction memory
        logic  to_data;
        addr_t addr;
        word_t data;
    } load_t;

endpackage

`default_nettype wire

//--- source/control_sequencer.sv
`default_nettype none

module control_sequencer
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    zero,
    input  opcode_t opcode,
    output ctrl_t   ctrl,
    output logic    busy,
    output logic    done
);

    seq_state_t state;
    seq_state_t state_nxt;
    ctrl_t      ctrl_nxt;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Start pulse kicks off the first fetch
                if (start) begin
                    state_nxt = FETCH1;
                end
            end
            FETCH1: state_nxt = FETCH2;
            FETCH2: state_nxt = FETCH3;
            FETCH3: begin
                // IR already holds the new word here
                case (opcode)
                    OP_LDAC: state_nxt = LDAC1;
                    OP_STAC: state_nxt = STAC1;
                    OP_MVAC: state_nxt = MVAC1;
                    OP_ADD:  state_nxt = ADD1;
                    OP_SUB:  state_nxt = SUB1;
                    OP_MUL:  state_nxt = MUL1;
                    OP_INAC: state_nxt = INAC1;
                    OP_CLAC: state_nxt = CLAC1;
                    OP_JPNZ: state_nxt = JPNZ1;
                    OP_END:  state_nxt = ENDOP;
                    default: state_nxt = NOP1;
                endcase
            end
            LDAC1: state_nxt = LDAC2;
            LDAC2: state_nxt = LDAC3;
            STAC1: state_nxt = STAC2;
            ADD1:  state_nxt = ADD2;
            SUB1:  state_nxt = SUB2;
            MUL1:  state_nxt = MUL2;
            // Halt until reset
            ENDOP: state_nxt = ENDOP;
            // Last execute cycle of every instruction
            default: state_nxt = FETCH1;
        endcase
    end

    // Strobe set for the state being entered, all else zero
    always_comb begin
        ctrl_nxt = '0;
        case (state_nxt)
            FETCH1: begin
                // Read word at PC, step PC past it
                ctrl_nxt.im_rd  = 1'b1;
                ctrl_nxt.pc_inc = 1'b1;
            end
            FETCH2: ctrl_nxt.ir_wr = 1'b1;
            // Operand field into AR
            FETCH3: ctrl_nxt.ar_wr = 1'b1;
            LDAC1:  ctrl_nxt.dm_rd = 1'b1;
            LDAC2:  ctrl_nxt.dr_from_dm = 1'b1;
            LDAC3:  ctrl_nxt.ac_from_dr = 1'b1;
            STAC1:  ctrl_nxt.dr_from_ac = 1'b1;
            STAC2:  ctrl_nxt.dm_wr = 1'b1;
            MVAC1:  ctrl_nxt.r_from_ac = 1'b1;
            // Op select first, AC write one cycle later
            ADD1:   ctrl_nxt.alu_op = ALU_ADD;
            SUB1:   ctrl_nxt.alu_op = ALU_SUB;
            MUL1:   ctrl_nxt.alu_op = ALU_MUL;
            ADD2, SUB2, MUL2: ctrl_nxt.ac_from_alu = 1'b1;
            INAC1:  ctrl_nxt.ac_inc = 1'b1;
            CLAC1:  ctrl_nxt.ac_clear = 1'b1;
            // Branch taken only on nonzero AC
            JPNZ1:  ctrl_nxt.pc_wr = ~zero;
            default: ctrl_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ctrl  <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            ctrl  <= ctrl_nxt;
            // Busy from first fetch up to the halt
            busy  <= (state_nxt != IDLE) && (state_nxt != ENDOP);
            done  <= (state_nxt == ENDOP);
        end
    end

    // At most one AC source per cycle
    a_ac_src_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.ac_inc, ctrl.ac_clear, ctrl.ac_from_alu, ctrl.ac_from_dr})
    );

    // Done only in the halt state, and it sticks
    a_done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (state == ENDOP) ##1 (done && !busy)
    );

endmodule

`default_nettype wire

//--- source/insn_fetch.sv
`default_nettype none

module insn_fetch
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  ctrl_t   ctrl,
    input  load_t   load,
    output opcode_t opcode,
    output addr_t   operand,
    output addr_t   pc
);

    // Program store
    word_t imem [MEM_DEPTH];
    // Synchronous read word
    word_t im_q;
    word_t ir;
    addr_t pc_q;
    addr_t ar;

    // Load port and registered read
    always_ff @(posedge clk) begin
        if (load.en && !load.to_data) begin
            imem[load.addr] <= load.data;
        end
        if (ctrl.im_rd) begin
            im_q <= imem[pc_q];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
            ir   <= '0;
            ar   <= '0;
        end else begin
            // Jump target comes from AR
            if (ctrl.pc_wr) begin
                pc_q <= ar;
            end else if (ctrl.pc_inc) begin
                pc_q <= pc_q + 1'b1;
            end
            if (ctrl.ir_wr) begin
                ir <= im_q;
            end
            // Low byte of IR is the operand address
            if (ctrl.ar_wr) begin
                ar <= ir[ADDR_W-1:0];
            end
        end
    end

    // Top nibble to the decoder
    assign opcode  = opcode_t'(ir[DATA_W-1 -: OPCODE_W]);
    assign operand = ar;
    assign pc      = pc_q;

    // Increment and jump are separate states
    a_pc_single_src: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.pc_inc && ctrl.pc_wr)
    );

endmodule

`default_nettype wire

//--- source/acc_datapath.sv
`default_nettype none

module acc_datapath
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t ctrl,
    input  word_t dr_in,
    output word_t ac_out,
    output logic  zero
);

    word_t   ac;
    word_t   r;
    word_t   dr;
    // ALU op from the state before, result used one cycle later
    alu_op_t alu_op_q;
    word_t   alu_res;

    // ALU on AC and R, low 16 bits kept
    always_comb begin
        case (alu_op_q)
            ALU_ADD: alu_res = ac + r;
            ALU_SUB: alu_res = ac - r;
            ALU_MUL: alu_res = ac * r;
            default: alu_res = ac;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ac       <= '0;
            r        <= '0;
            dr       <= '0;
            alu_op_q <= ALU_NONE;
        end else begin
            alu_op_q <= ctrl.alu_op;

            // AC sources are mutually exclusive
            if (ctrl.ac_clear) begin
                ac <= '0;
            end else if (ctrl.ac_inc) begin
                ac <= ac + 1'b1;
            end else if (ctrl.ac_from_alu) begin
                ac <= alu_res;
            end else if (ctrl.ac_from_dr) begin
                ac <= dr;
            end

            if (ctrl.r_from_ac) begin
                r <= ac;
            end

            // DR from memory on LDAC, from AC on STAC
            if (ctrl.dr_from_dm) begin
                dr <= dr_in;
            end else if (ctrl.dr_from_ac) begin
                dr <= ac;
            end
        end
    end

    assign ac_out = ac;
    // Branch flag for JPNZ
    assign zero   = (ac == '0);

    // AC write from ALU needs an op selected the cycle before
    a_alu_op_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.ac_from_alu |-> $past(ctrl.alu_op) != ALU_NONE
    );

    // DR load from memory always preceded by a read
    a_dr_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.dr_from_dm |-> $past(ctrl.dm_rd)
    );

endmodule

`default_nettype wire

//--- source/data_memory.sv
`default_nettype none

module data_memory
    import cpu_pkg::*;
(
    input  logic  clk,
    input  ctrl_t ctrl,
    input  load_t load,
    input  addr_t addr,
    input  word_t wr_data,
    output word_t rd_data
);

    word_t dmem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        // Preload while idle, else STAC write
        if (load.en && load.to_data) begin
            dmem[load.addr] <= load.data;
        end else if (ctrl.dm_wr) begin
            dmem[addr] <= wr_data;
        end
        // LDAC read, picked up by DR next cycle
        if (ctrl.dm_rd) begin
            rd_data <= dmem[addr];
        end
    end

    // Load port and STAC never collide
    a_no_load_on_write: assert property (
        @(posedge clk)
        !(load.en && ctrl.dm_wr)
    );

endmodule

`default_nettype wire

//--- source/accum_cpu.sv
`default_nettype none

module accum_cpu
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  load_t load,
    output word_t ac,
    output addr_t pc,
    output logic  busy,
    output logic  done
);

    // Strobes from the sequencer to every block
    ctrl_t   ctrl;
    // Decode inputs
    opcode_t opcode;
    logic    zero;
    // Data memory address and read path into DR
    addr_t   operand;
    word_t   dm_rd_data;

    // Decode
    control_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .zero   (zero),
        .opcode (opcode),
        .ctrl   (ctrl),
        .busy   (busy),
        .done   (done)
    );

    // PC, IR, AR and program store
    insn_fetch u_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .load    (load),
        .opcode  (opcode),
        .operand (operand),
        .pc      (pc)
    );

    // Execute
    acc_datapath u_dp (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .dr_in  (dm_rd_data),
        .ac_out (ac),
        .zero   (zero)
    );

    // Result store, written from AC
    data_memory u_dmem (
        .clk     (clk),
        .ctrl    (ctrl),
        .load    (load),
        .addr    (operand),
        .wr_data (ac),
        .rd_data (dm_rd_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_accum_cpu.sv
`default_nettype none

module tb_accum_cpu
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MARGIN = 40;

    logic  clk;
    logic  rst_n;
    logic  start;
    load_t load;
    word_t ac;
    addr_t pc;
    logic  busy;
    logic  done;

    // Program image and data preload for the current test
    word_t prog [MEM_DEPTH];
    int    prog_len;
    addr_t dinit_addr[$];
    word_t dinit_data[$];

    // Reference model results
    word_t exp_ac;
    addr_t exp_pc;
    int    exp_cycles;

    int cycle = 0;
    int budget = MARGIN;
    int checks = 0;
    int errors = 0;
    int programs = 0;

    // Halt tracking for the negedge monitor
    logic  halted;
    word_t ac_hold;
    addr_t pc_hold;

    accum_cpu dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .load  (load),
        .ac    (ac),
        .pc    (pc),
        .busy  (busy),
        .done  (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        checks++;
        assert (got == exp) else report_mismatch(name, exp, got);
    endtask

    // Machine must go busy right after an accepted start
    a_busy_after_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        (start && !busy && !done) |=> busy
    ) else report_mismatch("busy", 32'd1, {31'd0, $sampled(busy)});

    a_done_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> !busy
    ) else report_mismatch("busy", 32'd0, {31'd0, $sampled(busy)});

    // Program and data loads only while the machine is idle
    a_load_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        load.en |-> !busy
    ) else report_mismatch("busy", 32'd0, {31'd0, $sampled(busy)});

    // Once halted, done, busy, pc and ac are frozen
    always @(negedge clk) begin
        if (!rst_n) begin
            halted = 1'b0;
        end else if (!halted) begin
            pc_hold = pc;
            ac_hold = ac;
            halted  = done;
        end else begin
            expect_equal("done", 32'd1, {31'd0, done});
            expect_equal("busy", 32'd0, {31'd0, busy});
            expect_equal("pc", {24'd0, pc_hold}, {24'd0, pc});
            expect_equal("ac", {16'd0, ac_hold}, {16'd0, ac});
        end
    end

    function automatic word_t insn(input logic [3:0] op, input addr_t a);
        return {op, 4'h0, a};
    endfunction

    // Execute cycles per opcode without END
    function automatic int exec_cycles(input logic [3:0] op);
        case (op)
            OP_LDAC: return 3;
            OP_STAC, OP_ADD, OP_SUB, OP_MUL: return 2;
            default: return 1;
        endcase
    endfunction

    task automatic clear_program();
        for (int i = 0; i < MEM_DEPTH; i++) prog[i] = '0;
        prog_len = 0;
        dinit_addr.delete();
        dinit_data.delete();
    endtask

    task automatic emit(input logic [3:0] op, input addr_t a);
        prog[prog_len] = insn(op, a);
        prog_len++;
    endtask

    task automatic preset(input addr_t a, input word_t d);
        dinit_addr.push_back(a);
        dinit_data.push_back(d);
    endtask

    // Instruction level interpreter
    task automatic model_run();
        word_t      mem [MEM_DEPTH];
        word_t      w;
        word_t      acc;
        word_t      r;
        addr_t      p;
        logic [3:0] op;
        int         sum;
        int         steps;
        acc = '0;
        r = '0;
        p = '0;
        sum = 0;
        steps = 0;
        foreach (dinit_addr[i]) mem[dinit_addr[i]] = dinit_data[i];
        while (steps < 2000) begin
            w = prog[p];
            op = w[15:12];
            p = p + 8'd1;
            sum += 3;
            steps++;
            if (op == OP_END) break;
            case (op)
                OP_LDAC: acc = mem[w[7:0]];
                OP_STAC: mem[w[7:0]] = acc;
                OP_MVAC: r = acc;
                OP_ADD:  acc = acc + r;
                OP_SUB:  acc = acc - r;
                OP_MUL:  acc = acc * r;
                OP_INAC: acc = acc + 16'd1;
                OP_CLAC: acc = '0;
                OP_JPNZ: if (acc != '0) p = w[7:0];
                default: ;
            endcase
            sum += exec_cycles(op);
        end
        if (steps >= 2000) begin
            errors++;
            $display("Reference model never reached END in program %0d", programs);
        end
        exp_ac = acc;
        exp_pc = p;
        exp_cycles = 1 + sum;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #1 load = '{en: 1'b1, to_data: 1'b0, addr: addr_t'(i), data: prog[i]};
        end
        foreach (dinit_addr[i]) begin
            @(posedge clk);
            #1 load = '{en: 1'b1, to_data: 1'b1, addr: dinit_addr[i], data: dinit_data[i]};
        end
        @(posedge clk);
        #1 load = '0;
    endtask

    task automatic run_program();
        int t0;
        model_run();
        budget = budget + 20 + prog_len + dinit_addr.size() + exp_cycles + MARGIN;
        reset_dut();
        @(negedge clk);
        expect_equal("busy", 32'd0, {31'd0, busy});
        expect_equal("done", 32'd0, {31'd0, done});
        expect_equal("ac", 32'd0, {16'd0, ac});
        expect_equal("pc", 32'd0, {24'd0, pc});
        load_program();
        // Cycles counted from the edge that launches start
        @(posedge clk);
        #1 start = 1'b1;
        t0 = cycle;
        @(posedge clk);
        #1 start = 1'b0;
        @(negedge clk);
        while (!done) @(negedge clk);
        expect_equal("cycles", exp_cycles, cycle - t0);
        expect_equal("ac", {16'd0, exp_ac}, {16'd0, ac});
        expect_equal("pc", {24'd0, exp_pc}, {24'd0, pc});
        // Late start pulse must be ignored by the halted machine
        repeat (3) @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        repeat (6) @(posedge clk);
        programs++;
    endtask

    initial begin : watchdog
        wait (cycle > budget);
        $display("Watchdog expired at cycle %0d before the tests finished", cycle);
        $display("Programs: %0d, checks: %0d, errors: %0d", programs, checks, errors);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        word_t       x;
        int          n;
        rst_n = 1'b0;
        start = 1'b0;
        load  = '0;
        rnd = $urandom(32'hd3b4893e);

        // Memory round trip through a second address
        clear_program();
        rnd = $urandom;
        x = rnd[15:0];
        preset(8'h40, x);
        preset(8'h80, ~x);
        emit(OP_LDAC, 8'h40);
        emit(OP_STAC, 8'h80);
        emit(OP_CLAC, 8'h00);
        emit(OP_LDAC, 8'h80);
        emit(OP_END, 8'h00);
        run_program();

        // ALU ops over random operands
        for (int k = 0; k < 6; k++) begin
            clear_program();
            rnd = $urandom;
            preset(8'h20, rnd[15:0]);
            preset(8'h21, rnd[31:16]);
            emit(OP_LDAC, 8'h21);
            emit(OP_MVAC, 8'h00);
            emit(OP_LDAC, 8'h20);
            case (k % 3)
                0: emit(OP_ADD, 8'h00);
                1: emit(OP_SUB, 8'h00);
                default: emit(OP_MUL, 8'h00);
            endcase
            n = $urandom_range(3, 0);
            repeat (n) emit(OP_INAC, 8'h00);
            if (k == 4) begin
                emit(OP_CLAC, 8'h00);
                emit(OP_INAC, 8'h00);
            end
            // Unused opcodes run as no-ops
            if (k == 5) begin
                emit(4'hF, 8'h00);
                emit(4'h0, 8'h00);
            end
            emit(OP_END, 8'h00);
            run_program();
        end

        // Countdown loop with R holding 1
        clear_program();
        n = $urandom_range(8, 1);
        preset(8'h30, word_t'(n));
        preset(8'h31, 16'd1);
        emit(OP_LDAC, 8'h31);
        emit(OP_MVAC, 8'h00);
        emit(OP_LDAC, 8'h30);
        emit(OP_SUB, 8'h00);
        emit(OP_JPNZ, 8'h03);
        emit(OP_END, 8'h00);
        run_program();
        expect_equal("pc", 32'd6, {24'd0, pc});

        // Zero AC falls through the branch
        clear_program();
        emit(OP_CLAC, 8'h00);
        emit(OP_JPNZ, 8'h20);
        emit(OP_INAC, 8'h00);
        emit(OP_END, 8'h00);
        run_program();

        $display("Programs: %0d, checks: %0d, errors: %0d", programs, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/cpu_pkg.sv
source/control_sequencer.sv
source/insn_fetch.sv
source/acc_datapath.sv
source/data_memory.sv
source/accum_cpu.sv
verif/tb_accum_cpu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_accum_cpu -Mdir obj_dir -f src.f \
    && ./obj_dir/Vtb_accum_cpu | tee /dev/stderr | grep -qx "Result: PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
